// File: test/core_golden.txt
# I <word>            program word, loaded in order from address 0
# S <address> <data>  expected store, in the order it reaches the data memory
I FFB00093  # 00 addi x1, x0, -5
I 00300113  # 04 addi x2, x0, 3
I 401101B3  # 08 sub  x3, x2, x1
I 4020D233  # 0C sra  x4, x1, x2
I 00302023  # 10 sw   x3, 0(x0)
I 00402223  # 14 sw   x4, 4(x0)
I 0020A2B3  # 18 slt  x5, x1, x2
I 0020B333  # 1C sltu x6, x1, x2
I 123453B7  # 20 lui  x7, 0x12345
I 00538433  # 24 add  x8, x7, x5
I 00802423  # 28 sw   x8, 8(x0)
I 00602623  # 2C sw   x6, 12(x0)
I 00002503  # 30 lw   x10, 0(x0)
I 06450593  # 34 addi x11, x10, 100
I 00B02823  # 38 sw   x11, 16(x0)
I 00210463  # 3C beq  x2, x2, +8
I 04102023  # 40 sw   x1, 64(x0)
I 04208863  # 44 beq  x1, x2, 0x94
I 00209463  # 48 bne  x1, x2, +8
I 04102023  # 4C sw   x1, 64(x0)
I 04211263  # 50 bne  x2, x2, 0x94
I 0020C463  # 54 blt  x1, x2, +8
I 04102023  # 58 sw   x1, 64(x0)
I 02114C63  # 5C blt  x2, x1, 0x94
I 00115463  # 60 bge  x2, x1, +8
I 04102023  # 64 sw   x1, 64(x0)
I 0220D663  # 68 bge  x1, x2, 0x94
I 00116463  # 6C bltu x2, x1, +8
I 04102023  # 70 sw   x1, 64(x0)
I 0220E063  # 74 bltu x1, x2, 0x94
I 0020F463  # 78 bgeu x1, x2, +8
I 04102023  # 7C sw   x1, 64(x0)
I 00117A63  # 80 bgeu x2, x1, 0x94
I 00C006EF  # 84 jal  x13, +12
I 04102023  # 88 sw   x1, 64(x0)
I 04102023  # 8C sw   x1, 64(x0)
I 00D02A23  # 90 sw   x13, 20(x0)
I 0000006F  # 94 jal  x0, 0
S 00000000 00000008  # 3 - (-5)
S 00000004 FFFFFFFF  # -5 >>> 3
S 00000008 12345001  # lui plus slt of -5 < 3
S 0000000C 00000000  # sltu of 0xFFFFFFFB < 3
S 00000010 0000006C  # loaded 8 plus 100
S 00000014 00000088  # link of jal at 0x84

// File: project.f
design/isa_pkg.sv
design/core_pkg.sv
design/instruction_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/hazard_unit.sv
design/pipeline_core.sv
test/core_chk.sv
test/core_tb.sv

// File: test/core_tb.sv
module core_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic  clk;
    logic  reset;
    word_t instruction_address;
    word_t instruction_data;
    word_t data_address;
    logic  data_read_enable;
    logic  data_write_enable;
    word_t data_write_data;
    word_t data_read_data;

    // Word-addressed models, 256 words each
    word_t instruction_memory [256];
    word_t data_memory [256];
    word_t expected_addresses [$];
    word_t expected_values [$];
    int    program_words;
    int    store_count;
    logic  golden_loaded;

    pipeline_core pipeline_core_i (
        .clk                 (clk),
        .reset               (reset),
        .instruction_address (instruction_address),
        .instruction_data    (instruction_data),
        .data_address        (data_address),
        .data_read_enable    (data_read_enable),
        .data_write_enable   (data_write_enable),
        .data_write_data     (data_write_data),
        .data_read_data      (data_read_data)
    );

    bind pipeline_core core_chk core_chk_i (
        .clk               (clk),
        .reset             (reset),
        .data_read_enable  (data_read_enable),
        .data_write_enable (data_write_enable),
        .data_address      (data_address)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++)
        begin
            instruction_memory[i] = '0;
            data_memory[i]        = '0;
        end
    endtask

    // I lines fill the program from address 0 and S lines queue the expected stores
    task automatic read_golden();
        int    fd;
        int    fields;
        string line;
        word_t first_word;
        word_t second_word;
        fd = $fopen("test/core_golden.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("Cannot open test/core_golden.txt for reading");
            abort_run();
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line[0] == "I")
            begin
                fields = $sscanf(line.substr(1, line.len() - 1), "%h", first_word);
                assert (fields == 1)
                else
                begin
                    $display("Malformed program line in golden file: %s", line);
                    abort_run();
                end
                instruction_memory[program_words] = first_word;
                program_words++;
            end
            else if (line.len() > 1 && line[0] == "S")
            begin
                fields = $sscanf(line.substr(1, line.len() - 1), "%h %h",
                                 first_word, second_word);
                assert (fields == 2)
                else
                begin
                    $display("Malformed store line in golden file: %s", line);
                    abort_run();
                end
                expected_addresses.push_back(first_word);
                expected_values.push_back(second_word);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_store(input word_t address, input word_t value);
        assert (store_count < expected_addresses.size())
        else
        begin
            $display("Store of %h to address %h at %0t ns was not expected",
                     value, address, $time);
            abort_run();
        end
        assert (address == expected_addresses[store_count])
        else
        begin
            $display("MISMATCH at %0t ns: data_address is %h, expected %h",
                     $time, address, expected_addresses[store_count]);
            abort_run();
        end
        assert (value == expected_values[store_count])
        else
        begin
            $display("MISMATCH at %0t ns: data_write_data is %h, expected %h",
                     $time, value, expected_values[store_count]);
            abort_run();
        end
        store_count++;
    endtask

    // Memory answers land 10 ns after the edge when the addresses have settled
    always @(posedge clk)
    begin
        #10;
        instruction_data = instruction_memory[instruction_address[9:2]];
        data_read_data   = data_read_enable ? data_memory[data_address[9:2]] : 'x;
    end

    always @(posedge clk)
    begin
        if (!reset && data_write_enable === 1'b1)
        begin
            data_memory[data_address[9:2]] = data_write_data;
            check_store(data_address, data_write_data);
        end
    end

    initial
    begin
        wait (golden_loaded);
        repeat (30 * program_words + 100) @(posedge clk);
        $display("Timeout after %0d cycles, the expected stores did not all appear",
                 30 * program_words + 100);
        abort_run();
    end

    initial
    begin
        wait (pipeline_core_i.core_chk_i.violations != 0);
        $display("An assertion on the data memory port failed at %0t ns", $time);
        abort_run();
    end

    initial
    begin
        $timeformat(-9, 0, "", 0);
        clk              = 1'b0;
        reset            = 1'b1;
        instruction_data = '0;
        data_read_data   = '0;
        store_count      = 0;
        program_words    = 0;
        golden_loaded    = 1'b0;
        clear_memories();
        read_golden();
        golden_loaded = 1'b1;

        // The first edge loads the stage registers and the next three must stay quiet
        @(posedge clk);
        repeat (3)
        begin
            @(posedge clk);
            assert (data_write_enable === 1'b0 && data_read_enable === 1'b0)
            else
            begin
                $display("A data memory enable was high during reset at %0t ns", $time);
                abort_run();
            end
        end
        #10;
        reset = 1'b0;

        @(negedge clk);
        assert (instruction_address === 32'h0000_0000)
        else
        begin
            $display("MISMATCH at %0t ns: instruction_address is %h, expected %h",
                     $time, instruction_address, 32'h0000_0000);
            abort_run();
        end

        // Any extra store in this window is caught by the store checker
        wait (store_count == expected_addresses.size());
        repeat (20) @(posedge clk);
        @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: test/core_chk.sv
module core_chk
    import core_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  data_read_enable,
    input logic  data_write_enable,
    input word_t data_address
);

    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed assertions
    int violations = 0;

    // One access per cycle on the data port
    exclusive_enables: assert property (@(posedge clk) disable iff (reset)
        !(data_read_enable && data_write_enable))
    else
    begin
        $error("data_read_enable and data_write_enable are high together");
        violations++;
    end

    word_aligned: assert property (@(posedge clk) disable iff (reset)
        (data_read_enable || data_write_enable) |-> data_address[1:0] == 2'b00)
    else
    begin
        $error("data access to address %h is not word aligned", data_address);
        violations++;
    end

    // The first reset edge clears the stage registers
    quiet_in_reset: assert property (@(posedge clk)
        reset ##1 reset |-> !data_read_enable && !data_write_enable)
    else
    begin
        $error("data memory enable high while reset is asserted");
        violations++;
    end

endmodule

// File: design/pipeline_core.sv
module pipeline_core
    import isa_pkg::*, core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t instruction_address,
    input  word_t instruction_data,
    output word_t data_address,
    output logic  data_read_enable,
    output logic  data_write_enable,
    output word_t data_write_data,
    input  word_t data_read_data
);

    // Fetch and decode
    word_t      pc;
    word_t      instruction_decode;
    word_t      pc_decode;
    opcode_t    opcode_decode;
    funct3_t    funct3_decode;
    reg_index_t read_index_1_decode;
    reg_index_t read_index_2_decode;
    reg_index_t write_index_decode;
    logic       read_enable_1_decode;
    logic       read_enable_2_decode;
    logic       write_enable_decode;
    alu_op_t    alu_op_decode;
    logic       use_immediate_decode;
    word_t      immediate_decode;
    word_t      register_data_1;
    word_t      register_data_2;
    word_t      operand_1_decode;
    word_t      operand_2_decode;
    logic       load_use_stall;

    // Execute
    word_t      pc_execute;
    opcode_t    opcode_execute;
    funct3_t    funct3_execute;
    alu_op_t    alu_op_execute;
    logic       use_immediate_execute;
    word_t      immediate_execute;
    word_t      operand_1_execute;
    word_t      operand_2_execute;
    reg_index_t write_index_execute;
    logic       write_enable_execute;
    word_t      result_execute;
    logic       jump_branch_enable;
    word_t      target_address;

    // Memory and write-back
    opcode_t    opcode_memory;
    reg_index_t write_index_memory;
    logic       write_enable_memory;
    word_t      result_memory;
    word_t      store_data_memory;
    word_t      memory_value;
    opcode_t    opcode_writeback;
    reg_index_t write_index_writeback;
    logic       write_enable_writeback;
    word_t      result_writeback;
    word_t      load_data_writeback;
    word_t      writeback_value;

    // -------------------------------------------------------------------
    // Fetch
    // -------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= RESET_ADDRESS;
        else if (jump_branch_enable)
            pc <= target_address;
        else if (!load_use_stall)
            pc <= pc + 32'd4;
    end

    assign instruction_address = pc;

    // A taken branch squashes the instruction being fetched
    always_ff @(posedge clk)
    begin
        if (reset || jump_branch_enable)
            instruction_decode <= NOP_WORD;
        else if (!load_use_stall)
            instruction_decode <= instruction_data;
    end

    always_ff @(posedge clk)
    begin
        if (!load_use_stall)
            pc_decode <= pc;
    end

    // -------------------------------------------------------------------
    // Decode
    // -------------------------------------------------------------------
    instruction_decoder decoder_i (
        .instruction   (instruction_decode),
        .opcode        (opcode_decode),
        .funct3        (funct3_decode),
        .read_index_1  (read_index_1_decode),
        .read_index_2  (read_index_2_decode),
        .write_index   (write_index_decode),
        .read_enable_1 (read_enable_1_decode),
        .read_enable_2 (read_enable_2_decode),
        .write_enable  (write_enable_decode),
        .alu_op        (alu_op_decode),
        .use_immediate (use_immediate_decode),
        .immediate     (immediate_decode)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (read_index_1_decode),
        .read_index_2 (read_index_2_decode),
        .write_enable (write_enable_writeback),
        .write_index  (write_index_writeback),
        .write_data   (writeback_value),
        .read_data_1  (register_data_1),
        .read_data_2  (register_data_2)
    );

    hazard_unit hazard_unit_i (
        .read_index_1           (read_index_1_decode),
        .read_index_2           (read_index_2_decode),
        .read_enable_1          (read_enable_1_decode),
        .read_enable_2          (read_enable_2_decode),
        .register_data_1        (register_data_1),
        .register_data_2        (register_data_2),
        .execute_write_index    (write_index_execute),
        .memory_write_index     (write_index_memory),
        .writeback_write_index  (write_index_writeback),
        .execute_write_enable   (write_enable_execute),
        .memory_write_enable    (write_enable_memory),
        .writeback_write_enable (write_enable_writeback),
        .execute_is_load        (opcode_execute == OP_LOAD),
        .execute_value          (result_execute),
        .memory_value           (memory_value),
        .writeback_value        (writeback_value),
        .operand_1              (operand_1_decode),
        .operand_2              (operand_2_decode),
        .load_use_stall         (load_use_stall)
    );

    // Bubble into execute on a flush or a load-use stall
    always_ff @(posedge clk)
    begin
        if (reset || jump_branch_enable || load_use_stall)
        begin
            opcode_execute       <= OP_IMM;
            write_enable_execute <= 1'b0;
        end
        else
        begin
            opcode_execute       <= opcode_decode;
            write_enable_execute <= write_enable_decode;
        end
    end

    always_ff @(posedge clk)
    begin
        pc_execute            <= pc_decode;
        funct3_execute        <= funct3_decode;
        alu_op_execute        <= alu_op_decode;
        use_immediate_execute <= use_immediate_decode;
        immediate_execute     <= immediate_decode;
        operand_1_execute     <= operand_1_decode;
        operand_2_execute     <= operand_2_decode;
        write_index_execute   <= write_index_decode;
    end

    // -------------------------------------------------------------------
    // Execute
    // -------------------------------------------------------------------
    execute_unit execute_unit_i (
        .opcode             (opcode_execute),
        .funct3             (funct3_execute),
        .alu_op             (alu_op_execute),
        .use_immediate      (use_immediate_execute),
        .operand_1          (operand_1_execute),
        .operand_2          (operand_2_execute),
        .immediate          (immediate_execute),
        .pc                 (pc_execute),
        .result             (result_execute),
        .jump_branch_enable (jump_branch_enable),
        .target_address     (target_address)
    );

    // Control of the memory and write-back stages
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            opcode_memory          <= OP_IMM;
            write_enable_memory    <= 1'b0;
            opcode_writeback       <= OP_IMM;
            write_enable_writeback <= 1'b0;
        end
        else
        begin
            opcode_memory          <= opcode_execute;
            write_enable_memory    <= write_enable_execute;
            opcode_writeback       <= opcode_memory;
            write_enable_writeback <= write_enable_memory;
        end
    end

    always_ff @(posedge clk)
    begin
        write_index_memory    <= write_index_execute;
        result_memory         <= result_execute;
        store_data_memory     <= operand_2_execute;
        write_index_writeback <= write_index_memory;
        result_writeback      <= result_memory;
        load_data_writeback   <= data_read_data;
    end

    // -------------------------------------------------------------------
    // Memory and write-back
    // -------------------------------------------------------------------
    assign data_address      = result_memory;
    assign data_write_data   = store_data_memory;
    assign data_read_enable  = (opcode_memory == OP_LOAD);
    assign data_write_enable = (opcode_memory == OP_STORE);

    // Loads forward their data as soon as memory answers
    assign memory_value    = data_read_enable ? data_read_data : result_memory;
    assign writeback_value = (opcode_writeback == OP_LOAD) ? load_data_writeback
                                                           : result_writeback;

endmodule

// File: design/hazard_unit.sv
module hazard_unit
    import isa_pkg::*, core_pkg::*;
(
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    input  logic       read_enable_1,
    input  logic       read_enable_2,
    input  word_t      register_data_1,
    input  word_t      register_data_2,
    input  reg_index_t execute_write_index,
    input  reg_index_t memory_write_index,
    input  reg_index_t writeback_write_index,
    input  logic       execute_write_enable,
    input  logic       memory_write_enable,
    input  logic       writeback_write_enable,
    input  logic       execute_is_load,
    input  word_t      execute_value,
    input  word_t      memory_value,
    input  word_t      writeback_value,
    output word_t      operand_1,
    output word_t      operand_2,
    output logic       load_use_stall
);

    // Youngest producer wins; x0 never forwards
    function automatic word_t forward_source(input reg_index_t index, input word_t value);
        word_t selected;
        selected = value;
        if (index != '0)
        begin
            if (execute_write_enable && execute_write_index == index)
                selected = execute_value;
            else if (memory_write_enable && memory_write_index == index)
                selected = memory_value;
            else if (writeback_write_enable && writeback_write_index == index)
                selected = writeback_value;
        end
        return selected;
    endfunction

    always_comb
    begin
        operand_1 = forward_source(read_index_1, register_data_1);
        operand_2 = forward_source(read_index_2, register_data_2);
    end

    // Load data only exists in memory, one stage too late for execute
    assign load_use_stall = execute_is_load && execute_write_enable
        && execute_write_index != '0
        && ((read_enable_1 && read_index_1 == execute_write_index)
         || (read_enable_2 && read_index_2 == execute_write_index));

endmodule

// File: design/execute_unit.sv
module execute_unit
    import isa_pkg::*, core_pkg::*;
(
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  alu_op_t alu_op,
    input  logic    use_immediate,
    input  word_t   operand_1,
    input  word_t   operand_2,
    input  word_t   immediate,
    input  word_t   pc,
    output word_t   result,
    output logic    jump_branch_enable,
    output word_t   target_address
);

    word_t      operand_b;
    word_t      alu_output;
    logic [4:0] shift_amount;
    logic       branch_taken;

    assign operand_b    = use_immediate ? immediate : operand_2;
    assign shift_amount = operand_b[4:0];

    // ALU, also the load and store address adder
    always_comb
    begin
        case (alu_op)
            ALU_ADD:    alu_output = operand_1 + operand_b;
            ALU_SUB:    alu_output = operand_1 - operand_b;
            ALU_SLL:    alu_output = operand_1 << shift_amount;
            ALU_SLT:    alu_output = {31'b0, $signed(operand_1) < $signed(operand_b)};
            ALU_SLTU:   alu_output = {31'b0, operand_1 < operand_b};
            ALU_XOR:    alu_output = operand_1 ^ operand_b;
            ALU_SRL:    alu_output = operand_1 >> shift_amount;
            ALU_SRA:    alu_output = $signed(operand_1) >>> shift_amount;
            ALU_OR:     alu_output = operand_1 | operand_b;
            ALU_AND:    alu_output = operand_1 & operand_b;
            ALU_PASS_B: alu_output = operand_b;
            default:    alu_output = '0;
        endcase
    end

    // Branch comparator, always on the two register operands
    always_comb
    begin
        case (funct3)
            F3_BEQ:  branch_taken = (operand_1 == operand_2);
            F3_BNE:  branch_taken = (operand_1 != operand_2);
            F3_BLT:  branch_taken = ($signed(operand_1) < $signed(operand_2));
            F3_BGE:  branch_taken = ($signed(operand_1) >= $signed(operand_2));
            F3_BLTU: branch_taken = (operand_1 < operand_2);
            F3_BGEU: branch_taken = (operand_1 >= operand_2);
            default: branch_taken = 1'b0;
        endcase
    end

    assign jump_branch_enable = (opcode == OP_JAL) || (opcode == OP_BRANCH && branch_taken);
    assign target_address     = pc + immediate;

    // JAL carries its return address down the pipe in place of an ALU value
    assign result = (opcode == OP_JAL) ? pc + 32'd4 : alu_output;

endmodule

// File: design/register_file.sv
module register_file
    import isa_pkg::*, core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_data,
    output word_t      read_data_1,
    output word_t      read_data_2
);

    word_t registers [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                registers[i] <= '0;
        end
        else if (write_enable && write_index != '0)
            registers[write_index] <= write_data;
    end

    // x0 keeps its reset value, so it always reads zero
    assign read_data_1 = registers[read_index_1];
    assign read_data_2 = registers[read_index_2];

endmodule

// File: design/instruction_decoder.sv
module instruction_decoder
    import isa_pkg::*, core_pkg::*;
(
    input  word_t      instruction,
    output opcode_t    opcode,
    output funct3_t    funct3,
    output reg_index_t read_index_1,
    output reg_index_t read_index_2,
    output reg_index_t write_index,
    output logic       read_enable_1,
    output logic       read_enable_2,
    output logic       write_enable,
    output alu_op_t    alu_op,
    output logic       use_immediate,
    output word_t      immediate
);

    funct7_t funct7;
    logic    alternate;

    assign opcode       = instruction[6:0];
    assign funct3       = instruction[14:12];
    assign funct7       = instruction[31:25];
    assign read_index_1 = instruction[19:15];
    assign read_index_2 = instruction[24:20];
    assign write_index  = instruction[11:7];

    // SUB and SRA share funct3 with ADD and SRL
    assign alternate = funct7[5];

    always_comb
    begin
        read_enable_1 = 1'b0;
        read_enable_2 = 1'b0;
        write_enable  = 1'b0;
        use_immediate = 1'b1;
        alu_op        = ALU_ADD;
        immediate     = '0;
        case (opcode)
            OP_LUI:
            begin
                write_enable = 1'b1;
                alu_op       = ALU_PASS_B;
                immediate    = {instruction[31:12], 12'b0};
            end
            OP_JAL:
            begin
                write_enable = 1'b1;
                immediate    = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                                instruction[20], instruction[30:21], 1'b0};
            end
            OP_BRANCH:
            begin
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                use_immediate = 1'b0;
                immediate     = {{19{instruction[31]}}, instruction[31], instruction[7],
                                 instruction[30:25], instruction[11:8], 1'b0};
            end
            OP_LOAD:
            begin
                read_enable_1 = 1'b1;
                write_enable  = 1'b1;
                immediate     = {{20{instruction[31]}}, instruction[31:20]};
            end
            OP_STORE:
            begin
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                immediate     = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            OP_IMM, OP_REG:
            begin
                read_enable_1 = 1'b1;
                read_enable_2 = (opcode == OP_REG);
                write_enable  = 1'b1;
                use_immediate = (opcode == OP_IMM);
                immediate     = {{20{instruction[31]}}, instruction[31:20]};
                case (funct3)
                    F3_ADD:  alu_op = (opcode == OP_REG && alternate) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = alternate ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                endcase
            end
            // unsupported opcodes write nothing and touch no memory
            default:
                write_enable = 1'b0;
        endcase
    end

endmodule

// File: design/core_pkg.sv
package core_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // ALU operation code
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // Second operand straight through, for LUI
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // First fetch address after reset
    localparam word_t RESET_ADDRESS = 32'h0000_0000;

    // Integer register count
    localparam int REG_COUNT = 32;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    // Instruction field types
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_index_t;

    // Major opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Arithmetic and logic functions, shared by OP and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage
